/* verilog/cpu_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared widths and types for the back half of the pipeline
//////////////////////////////////////////////////////////////////////
package cpu_pkg;

  // Datapath width of the whole CPU
  parameter int DATA_WIDTH = 16;

  // Sixteen architectural registers
  parameter int REG_ADDR_WIDTH = 4;

  // One data word as it moves through the datapath
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Register number where register 0 never forwards
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Memory stage controls, 18 bits with the store word on top
  typedef struct packed {
    data_t store_data; // Word written on a store
    logic  mem_en;     // Memory access enable
    logic  mem_write;  // High for a store and low for a load
  } mem_ctrl_t;

  // Write-back stage controls, 8 bits with the destination on top
  typedef struct packed {
    reg_addr_t reg_rd;     // Destination register
    logic      reg_write;  // Register write enable
    logic      mem_to_reg; // Take the load result
    logic      hlt;        // Halt marker
    logic      pcs;        // Write the next PC
  } wb_ctrl_t;

  // A bubble is simply all zeros in both control words
  parameter mem_ctrl_t MEM_CTRL_NOP = '0;
  parameter wb_ctrl_t  WB_CTRL_NOP  = '0;

endpackage

`default_nettype wire

/* verilog/ex_mem_if.sv */
`default_nettype none

// Contents of the EX/MEM register as seen by the memory stage
interface ex_mem_if;
  import cpu_pkg::*;

  data_t     pc_next;  // Next PC of the instruction in MEM
  data_t     alu_out;  // ALU result which is also the memory address
  reg_addr_t src_reg2; // Second source register of the instruction
  mem_ctrl_t mem_ctrl; // Store word already resolved for forwarding
  wb_ctrl_t  wb_ctrl;  // Controls carried on to write-back

  // The EX/MEM register drives everything
  modport stage_out (
    output pc_next, alu_out, src_reg2, mem_ctrl, wb_ctrl
  );

  // Memory and MEM/WB register only read
  modport stage_in (
    input pc_next, alu_out, src_reg2, mem_ctrl, wb_ctrl
  );

endinterface

`default_nettype wire

/* verilog/mem_wb_if.sv */
`default_nettype none

// Write-back view of the MEM/WB register after source selection
interface mem_wb_if;
  import cpu_pkg::*;

  logic      reg_write;   // Write enable with halt gating applied
  reg_addr_t reg_rd;      // Destination register
  data_t     wb_data;     // Selected write-back word
  logic      valid_write; // A real write to a nonzero register

  // Driven by the MEM/WB register
  modport stage_out (
    output reg_write, reg_rd, wb_data, valid_write
  );

  // Forwarding logic in EX/MEM looks at the instruction two edges ahead
  modport fwd_view (
    input reg_write, reg_rd, wb_data, valid_write
  );

endinterface

`default_nettype wire

/* verilog/ex_mem_pipe_reg.sv */
`default_nettype none

module ex_mem_pipe_reg (
  input  logic               clk,            // System clock
  input  logic               reset,          // Synchronous active high reset
  input  cpu_pkg::data_t     id_ex_pc_next,  // Next PC from ID/EX
  input  cpu_pkg::data_t     alu_out,        // Result of the execute stage
  input  cpu_pkg::reg_addr_t id_ex_src_reg2, // Register that supplies the store word
  input  cpu_pkg::mem_ctrl_t id_ex_mem_ctrl, // Memory controls from ID/EX
  input  cpu_pkg::wb_ctrl_t  id_ex_wb_ctrl,  // Write-back controls from ID/EX
  mem_wb_if.fwd_view         wb_view,        // MEM/WB state for store forwarding
  ex_mem_if.stage_out        ex_mem          // Registered contents toward MEM
);
  import cpu_pkg::*;

  logic      is_store;      // Incoming instruction writes memory
  logic      fwd_store;     // Store word comes from MEM/WB
  mem_ctrl_t mem_ctrl_next; // Memory controls with the store word resolved

  //////////////////////////////////////////////////////////////////////
  // Store data forwarding
  //////////////////////////////////////////////////////////////////////
  assign is_store = id_ex_mem_ctrl.mem_en & id_ex_mem_ctrl.mem_write;

  // The register file has not seen the MEM/WB result yet, so the store
  // must take it straight from the write-back word
  assign fwd_store = is_store & wb_view.valid_write &
                     (wb_view.reg_rd == id_ex_src_reg2);

  always_comb begin
    mem_ctrl_next = id_ex_mem_ctrl;          // Enables always pass unchanged
    if (fwd_store) begin
      mem_ctrl_next.store_data = wb_view.wb_data; // Only the data field is replaced
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.pc_next  <= '0;
      ex_mem.alu_out  <= '0;
      ex_mem.src_reg2 <= '0;
      ex_mem.mem_ctrl <= MEM_CTRL_NOP; // No memory access after reset
      ex_mem.wb_ctrl  <= WB_CTRL_NOP;  // No register write after reset
    end else begin
      ex_mem.pc_next  <= id_ex_pc_next;
      ex_mem.alu_out  <= alu_out;
      ex_mem.src_reg2 <= id_ex_src_reg2;
      ex_mem.mem_ctrl <= mem_ctrl_next;
      ex_mem.wb_ctrl  <= id_ex_wb_ctrl;
    end
  end

endmodule

`default_nettype wire

/* verilog/data_memory.sv */
`default_nettype none

module data_memory #(
  parameter int ADDR_WIDTH = 8 // Memory holds 2**ADDR_WIDTH words
) (
  input  logic           clk,       // System clock
  ex_mem_if.stage_in     ex_mem,    // Address and controls from EX/MEM
  output cpu_pkg::data_t read_data  // Load result for MEM/WB
);
  import cpu_pkg::*;

  localparam int DEPTH = 1 << ADDR_WIDTH;

  data_t                 mem [DEPTH]; // Word storage with no reset
  logic [ADDR_WIDTH-1:0] addr;        // Word index into the array
  logic                  write_en;    // Store in the memory stage

  // Word addressing means the low bits of the ALU result pick the entry
  assign addr     = ex_mem.alu_out[ADDR_WIDTH-1:0];
  assign write_en = ex_mem.mem_ctrl.mem_en & ex_mem.mem_ctrl.mem_write;

  // Stores land at the end of the memory cycle
  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[addr] <= ex_mem.mem_ctrl.store_data;
    end
  end

  // Asynchronous read so the load result is ready before the MEM/WB edge
  assign read_data = ex_mem.mem_ctrl.mem_en ? mem[addr] : '0; // Idle reads give zero

endmodule

`default_nettype wire

/* verilog/mem_wb_pipe_reg.sv */
`default_nettype none

module mem_wb_pipe_reg (
  input  logic           clk,       // System clock
  input  logic           reset,     // Synchronous active high reset
  ex_mem_if.stage_in     ex_mem,    // Contents of EX/MEM
  input  cpu_pkg::data_t read_data, // Load result from data memory
  mem_wb_if.stage_out    mem_wb,    // Write-back result
  output logic           halted     // Sticky halt flag
);
  import cpu_pkg::*;

  data_t    pc_next_q;   // Next PC of the instruction in WB
  data_t    alu_out_q;   // ALU result of the instruction in WB
  data_t    read_data_q; // Load data of the instruction in WB
  wb_ctrl_t wb_ctrl_q;   // Write-back controls of the instruction in WB
  logic     halt_prev_q; // A halt already left the WB stage

  //////////////////////////////////////////////////////////////////////
  // Pipeline register and halt tracking
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_next_q   <= '0;
      alu_out_q   <= '0;
      read_data_q <= '0;
      wb_ctrl_q   <= WB_CTRL_NOP;
      halt_prev_q <= 1'b0;
    end else begin
      pc_next_q   <= ex_mem.pc_next;
      alu_out_q   <= ex_mem.alu_out;
      read_data_q <= read_data;
      wb_ctrl_q   <= ex_mem.wb_ctrl;
      halt_prev_q <= halt_prev_q | wb_ctrl_q.hlt; // Set once the halting instruction moves on
    end
  end

  // High from the cycle the halt sits in WB until the next reset
  assign halted = halt_prev_q | wb_ctrl_q.hlt;

  //////////////////////////////////////////////////////////////////////
  // Write-back selection
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (wb_ctrl_q.mem_to_reg) begin
      mem_wb.wb_data = read_data_q; // Load
    end else if (wb_ctrl_q.pcs) begin
      mem_wb.wb_data = pc_next_q;   // Link value for PCS
    end else begin
      mem_wb.wb_data = alu_out_q;
    end
  end

  // The halting instruction still writes and everything after it is blocked
  assign mem_wb.reg_write   = wb_ctrl_q.reg_write & ~halt_prev_q;
  assign mem_wb.reg_rd      = wb_ctrl_q.reg_rd;
  assign mem_wb.valid_write = mem_wb.reg_write & (wb_ctrl_q.reg_rd != '0); // R0 never forwards

endmodule

`default_nettype wire

/* verilog/mem_stage_top.sv */
`default_nettype none

module mem_stage_top #(
  parameter int MEM_ADDR_WIDTH = 8 // Log2 of the data memory depth in words
) (
  input  logic               clk,              // System clock
  input  logic               reset,            // Synchronous active high reset
  input  cpu_pkg::data_t     id_ex_pc_next,    // Next PC of the instruction in EX
  input  cpu_pkg::data_t     alu_out,          // ALU result and memory address
  input  cpu_pkg::reg_addr_t id_ex_src_reg2,   // Source register of the store word
  input  cpu_pkg::data_t     id_ex_store_data, // Store word read in decode
  input  logic               id_ex_mem_en,     // Memory access enable
  input  logic               id_ex_mem_write,  // Store when high and load when low
  input  cpu_pkg::reg_addr_t id_ex_reg_rd,     // Destination register
  input  logic               id_ex_reg_write,  // Register write enable
  input  logic               id_ex_mem_to_reg, // Write back the load data
  input  logic               id_ex_hlt,        // Halt marker
  input  logic               id_ex_pcs,        // Write back the next PC
  output logic               wb_reg_write,     // Register file write enable
  output cpu_pkg::reg_addr_t wb_reg_rd,        // Register file write address
  output cpu_pkg::data_t     wb_data,          // Register file write data
  output logic               halted            // CPU has halted
);
  import cpu_pkg::*;

  mem_ctrl_t id_ex_mem_ctrl; // Packed memory controls
  wb_ctrl_t  id_ex_wb_ctrl;  // Packed write-back controls
  data_t     read_data;      // Load result from memory to MEM/WB

  ex_mem_if u_ex_mem_if ();
  mem_wb_if u_mem_wb_if ();

  // Gather the flat decode outputs into the stage control words
  assign id_ex_mem_ctrl = '{store_data: id_ex_store_data,
                            mem_en:     id_ex_mem_en,
                            mem_write:  id_ex_mem_write};
  assign id_ex_wb_ctrl  = '{reg_rd:     id_ex_reg_rd,
                            reg_write:  id_ex_reg_write,
                            mem_to_reg: id_ex_mem_to_reg,
                            hlt:        id_ex_hlt,
                            pcs:        id_ex_pcs};

  ex_mem_pipe_reg u_ex_mem_pipe_reg (
    .clk            (clk),
    .reset          (reset),
    .id_ex_pc_next  (id_ex_pc_next),
    .alu_out        (alu_out),
    .id_ex_src_reg2 (id_ex_src_reg2),
    .id_ex_mem_ctrl (id_ex_mem_ctrl),
    .id_ex_wb_ctrl  (id_ex_wb_ctrl),
    .wb_view        (u_mem_wb_if.fwd_view),
    .ex_mem         (u_ex_mem_if.stage_out)
  );

  data_memory #(.ADDR_WIDTH(MEM_ADDR_WIDTH)) u_data_memory (
    .clk       (clk),
    .ex_mem    (u_ex_mem_if.stage_in),
    .read_data (read_data)
  );

  mem_wb_pipe_reg u_mem_wb_pipe_reg (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (u_ex_mem_if.stage_in),
    .read_data (read_data),
    .mem_wb    (u_mem_wb_if.stage_out),
    .halted    (halted)
  );

  // Register file side of the write-back result
  assign wb_reg_write = u_mem_wb_if.reg_write;
  assign wb_reg_rd    = u_mem_wb_if.reg_rd;
  assign wb_data      = u_mem_wb_if.wb_data;

endmodule

`default_nettype wire

/* tb/mem_stage_checker.sv */
`default_nettype none

module mem_stage_checker (
  input  logic               clk,           // Testbench clock
  input  logic               wb_reg_write,  // DUT register write enable
  input  cpu_pkg::reg_addr_t wb_reg_rd,     // DUT register write address
  input  cpu_pkg::data_t     wb_data,       // DUT register write data
  input  logic               halted,        // DUT halt flag
  input  logic               exp_chk,       // An expectation is due this cycle
  input  logic               exp_reg_write, // Expected write enable
  input  cpu_pkg::reg_addr_t exp_reg_rd,    // Expected write address
  input  cpu_pkg::data_t     exp_data,      // Expected write data
  input  logic               exp_halted,    // Expected halt flag
  output int                 err_count      // Mismatches seen so far
);
  import cpu_pkg::*;

  initial err_count = 0;

  task automatic report_mismatch(input string name, input logic [15:0] exp_val,
                                 input logic [15:0] act_val);
    err_count++;
    $display("ERR time %0t signal %s expected %h actual %h", $time, name, exp_val, act_val);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare on the falling edge where every DUT output has settled
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (exp_chk) begin
      if (wb_reg_write !== exp_reg_write) begin
        report_mismatch("wb_reg_write", 16'(exp_reg_write), 16'(wb_reg_write));
      end
      if (halted !== exp_halted) begin
        report_mismatch("halted", 16'(exp_halted), 16'(halted));
      end
      // Address and data only matter when the register file writes
      if (exp_reg_write) begin
        if (wb_reg_rd !== exp_reg_rd) begin
          report_mismatch("wb_reg_rd", 16'(exp_reg_rd), 16'(wb_reg_rd));
        end
        if (wb_data !== exp_data) begin
          report_mismatch("wb_data", exp_data, wb_data);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb/mem_stage_tb.sv */
`default_nettype none

module mem_stage_tb;
  import cpu_pkg::*;

  localparam int MEM_AW        = 8; // Memory address width handed to the DUT
  localparam int DRAIN_CYCLES  = 3; // Two edges of latency plus the compare edge
  localparam int HALT_WAIT_MAX = 8;

  // One expected write-back result
  typedef struct packed {
    logic      chk;
    logic      reg_write;
    reg_addr_t rd;
    data_t     data;
    logic      halted;
  } exp_t;

  logic      clk;
  logic      reset;
  data_t     id_ex_pc_next, alu_out, id_ex_store_data;
  reg_addr_t id_ex_src_reg2, id_ex_reg_rd;
  logic      id_ex_mem_en, id_ex_mem_write, id_ex_reg_write;
  logic      id_ex_mem_to_reg, id_ex_hlt, id_ex_pcs;
  logic      wb_reg_write;
  reg_addr_t wb_reg_rd;
  data_t     wb_data;
  logic      halted;

  exp_t        exp_s0, exp_s1, exp_s2;   // Expectation delay line, s2 is due now
  data_t       model_mem [1 << MEM_AW];  // Reference copy of the data memory
  logic [15:0] lfsr_state;
  logic        hlt_seen;                 // A halt has been issued
  logic        prev1_vw, prev2_vw;       // Valid writes of the last two issues
  reg_addr_t   prev1_rd, prev2_rd;
  data_t       prev1_data, prev2_data;
  int          err_count, err_snap, tests_passed, tests_failed, extra_fail;

  mem_stage_top #(.MEM_ADDR_WIDTH(MEM_AW)) u_mem_stage_top (.*);

  mem_stage_checker u_mem_stage_checker (
    .clk           (clk),
    .wb_reg_write  (wb_reg_write),
    .wb_reg_rd     (wb_reg_rd),
    .wb_data       (wb_data),
    .halted        (halted),
    .exp_chk       (exp_s2.chk),
    .exp_reg_write (exp_s2.reg_write),
    .exp_reg_rd    (exp_s2.rd),
    .exp_data      (exp_s2.data),
    .exp_halted    (exp_s2.halted),
    .err_count     (err_count)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    exp_s1 <= exp_s0; // Results leave the DUT two edges after sampling
    exp_s2 <= exp_s1;
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and the reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state); // One step for each bit taken
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Expected write-back of one instruction, stores before it already applied
  function automatic exp_t ref_result(input data_t pc, input data_t alu, input reg_addr_t rd,
                                      input logic reg_write, input logic mem_en,
                                      input logic mem_to_reg, input logic hlt, input logic pcs);
    exp_t e;
    e.chk       = 1'b1;
    e.reg_write = reg_write & ~hlt_seen; // Only instructions after the halt are blocked
    e.rd        = rd;
    if (mem_to_reg) begin
      e.data = mem_en ? model_mem[alu[MEM_AW-1:0]] : '0;
    end else if (pcs) begin
      e.data = pc;
    end else begin
      e.data = alu;
    end
    e.halted = hlt_seen | hlt;
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  task automatic issue(input data_t pc, input data_t alu, input reg_addr_t src2,
                       input data_t st_data, input logic mem_en, input logic mem_write,
                       input reg_addr_t rd, input logic reg_write, input logic mem_to_reg,
                       input logic hlt, input logic pcs);
    exp_t  e;
    logic  fwd;
    @(posedge clk);
    #1;
    {id_ex_pc_next, alu_out, id_ex_src_reg2, id_ex_store_data} = {pc, alu, src2, st_data};
    {id_ex_mem_en, id_ex_mem_write, id_ex_reg_rd} = {mem_en, mem_write, rd};
    {id_ex_reg_write, id_ex_mem_to_reg, id_ex_hlt, id_ex_pcs} = {reg_write, mem_to_reg, hlt, pcs};
    e   = ref_result(pc, alu, rd, reg_write, mem_en, mem_to_reg, hlt, pcs);
    fwd = mem_en & mem_write & prev2_vw & (prev2_rd == src2); // Source sits in MEM/WB
    if (mem_en & mem_write) begin
      model_mem[alu[MEM_AW-1:0]] = fwd ? prev2_data : st_data;
    end
    hlt_seen = hlt_seen | hlt;
    {prev2_vw, prev2_rd, prev2_data} = {prev1_vw, prev1_rd, prev1_data};
    {prev1_vw, prev1_rd, prev1_data} = {e.reg_write & (rd != '0), rd, e.data};
    exp_s0 = e;
  endtask

  task automatic issue_bubble();
    issue('0, '0, '0, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic finish_test(input string name);
    repeat (DRAIN_CYCLES) issue_bubble(); // Let every pending result reach the checker
    if (err_count != err_snap || extra_fail != 0) begin
      tests_failed++;
      $display("test %s: FAILED", name);
    end else begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    err_snap   = err_count;
    extra_fail = 0;
  endtask

  // Store through a register written two issues earlier, then load it back
  task automatic run_forward(input reg_addr_t rd);
    data_t va, raw, addr;
    va   = rand_bits(16);
    raw  = rand_bits(16);
    addr = rand_bits(16);
    if (raw == va) raw = ~va; // The loaded word must tell the two apart
    issue(rand_bits(16), va, '0, '0, 1'b0, 1'b0, rd, 1'b1, 1'b0, 1'b0, 1'b0);
    issue_bubble();
    issue(rand_bits(16), addr, rd, raw, 1'b1, 1'b1, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    issue_bubble();
    issue(rand_bits(16), addr, '0, '0, 1'b1, 1'b0, 4'd9, 1'b1, 1'b1, 1'b0, 1'b0);
  endtask

  initial begin
    data_t addrs [6];
    int    waited;
    clk = 1'b0;
    reset = 1'b1;
    {id_ex_pc_next, alu_out, id_ex_store_data, id_ex_src_reg2, id_ex_reg_rd} = '0;
    {id_ex_mem_en, id_ex_mem_write, id_ex_reg_write} = '0;
    {id_ex_mem_to_reg, id_ex_hlt, id_ex_pcs} = '0;
    {exp_s0, exp_s1, exp_s2} = '0;
    {prev1_vw, prev1_rd, prev1_data, prev2_vw, prev2_rd, prev2_data} = '0;
    lfsr_state = 16'd38;
    hlt_seen = 1'b0;
    {err_snap, tests_passed, tests_failed, extra_fail} = '0;

    repeat (4) issue_bubble(); // Reset covers four rising edges
    reset = 1'b0;
    finish_test("reset");

    for (int i = 0; i < 8; i++) begin
      issue(rand_bits(16), rand_bits(16), '0, '0, 1'b0, 1'b0, reg_addr_t'(rand_bits(4)),
            1'b1, 1'b0, 1'b0, 1'b0);
    end
    finish_test("alu write-back");

    for (int i = 0; i < 6; i++) begin
      addrs[i] = rand_bits(16);
      issue(rand_bits(16), addrs[i], '0, rand_bits(16), 1'b1, 1'b1, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    issue_bubble();
    for (int i = 0; i < 6; i++) begin
      issue(rand_bits(16), addrs[i], '0, '0, 1'b1, 1'b0, reg_addr_t'(i + 1),
            1'b1, 1'b1, 1'b0, 1'b0);
    end
    finish_test("store then load");

    for (int i = 0; i < 4; i++) begin
      issue(rand_bits(16), rand_bits(16), '0, '0, 1'b0, 1'b0, reg_addr_t'(i + 2),
            1'b1, 1'b0, 1'b0, 1'b1);
    end
    finish_test("pcs");

    run_forward(reg_addr_t'(rand_bits(3)) + 4'd1); // Any register but R0
    run_forward(4'd0);
    finish_test("forwarding");

    issue(rand_bits(16), rand_bits(16), '0, '0, 1'b0, 1'b0, 4'd3, 1'b1, 1'b0, 1'b1, 1'b0);
    waited = 0;
    while (!halted && waited < HALT_WAIT_MAX) begin
      issue_bubble();
      waited++;
    end
    if (!halted) begin
      $display("timeout: halted did not rise after the halt instruction");
      extra_fail++;
    end
    for (int i = 0; i < 4; i++) begin
      issue(rand_bits(16), rand_bits(16), '0, '0, 1'b0, 1'b0, reg_addr_t'(i + 5),
            1'b1, 1'b0, 1'b0, 1'b0);
    end
    finish_test("halt");

    $display("tests passed %0d, tests failed %0d, value errors %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/ex_mem_if.sv
verilog/mem_wb_if.sv
verilog/ex_mem_pipe_reg.sv
verilog/data_memory.sv
verilog/mem_wb_pipe_reg.sv
verilog/mem_stage_top.sv
tb/mem_stage_checker.sv
tb/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/ex_mem_if.sv
      - verilog/mem_wb_if.sv
      - verilog/ex_mem_pipe_reg.sv
      - verilog/data_memory.sv
      - verilog/mem_wb_pipe_reg.sv
      - verilog/mem_stage_top.sv
  - target: test
    files:
      - tb/mem_stage_checker.sv
      - tb/mem_stage_tb.sv
